// ==== common/alu_pkg.sv ====
// Shared definitions of the polar ALU
//   Datapath, word and lane widths, polar saturation limit
//   Operator codes and operator classes
//   Word/lane view of an operand
//   Operator to class mapping

package alu_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int XLEN      = 64;
    localparam int WORD_W    = 32;
    localparam int LANE_W    = 8;
    localparam int NUM_LANES = XLEN / LANE_W;
    localparam int SAT_MAX   = 127;
    localparam int OP_W      = 5;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic signed [LANE_W-1:0] lane_t;

    // --------------------------------------------------
    // Operators
    // --------------------------------------------------
    // Codes are dense from zero, PL_SPCXOR is the last one
    typedef enum logic [OP_W-1:0] {
        ADD, SUB, ADDW, SUBW,
        ANDL, ORL, XORL, ANDN, ORN, XNOR,
        SLL, SRL, SRA, SLLW, SRLW, SRAW,
        SLTS, SLTU,
        EQ, NE, LTS, LTU, GES, GEU,
        PL_R, PL_F, PL_G, PL_VADDREP, PL_SPCXOR
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_ARITH,
        CLS_LOGIC,
        CLS_SHIFT,
        CLS_BRANCH,
        CLS_POLAR
    } op_class_e;

    // One operand word, seen whole by the scalar units and per lane by polar
    typedef union packed {
        xlen_t                       word;
        lane_t [NUM_LANES-1:0]       lanes;
    } alu_word_u;

    // Which unit produces the result of an operator
    function automatic op_class_e op_class(alu_op_e op);
        op_class_e cls;
        case (op)
            ANDL, ORL, XORL, ANDN, ORN, XNOR:        cls = CLS_LOGIC;
            SLL, SRL, SRA, SLLW, SRLW, SRAW:         cls = CLS_SHIFT;
            EQ, NE, LTS, LTU, GES, GEU:              cls = CLS_BRANCH;
            PL_R, PL_F, PL_G, PL_VADDREP, PL_SPCXOR: cls = CLS_POLAR;
            // Adder ops and set-less-than
            default:                                 cls = CLS_ARITH;
        endcase
        return cls;
    endfunction

endpackage

// ==== dv/alu_tb_tasks.svh ====
// Testbench helpers for the polar ALU
//   Reference model of result and branch outcome
//   Compare, issue and drain tasks
//   Directed tests

function automatic logic [7:0] model_lane(alu_op_e op, int x, int y,
                                          logic [7:0] imm_lane, logic clear);
    int mag_x;
    int mag_y;
    int m;
    mag_x = (x < 0) ? -x : x;
    mag_y = (y < 0) ? -y : y;
    case (op)
        PL_R: m = (clear || x >= 0) ? 0 : 1;
        PL_F: begin
            m = (mag_y < mag_x) ? mag_y : mag_x;
            if ((x < 0) != (y < 0)) begin
                m = -m;
            end
        end
        default: begin
            m = (imm_lane == 8'd0) ? x + y : y - x;
            if (m > SAT_MAX) begin
                m = SAT_MAX;
            end else if (m < -SAT_MAX) begin
                m = -SAT_MAX;
            end
        end
    endcase
    return m[7:0];
endfunction

function automatic xlen_t model_result(alu_op_e op, xlen_t a, xlen_t b, xlen_t imm_w);
    xlen_t       r;
    logic [31:0] w;
    case (op)
        ADDW:    w = a[31:0] + b[31:0];
        SUBW:    w = a[31:0] - b[31:0];
        SLLW:    w = a[31:0] << b[4:0];
        SRLW:    w = a[31:0] >> b[4:0];
        SRAW:    w = $signed(a[31:0]) >>> b[4:0];
        default: w = '0;
    endcase
    r = '0;
    case (op)
        ADD:  r = a + b;
        SUB:  r = a - b;
        ADDW, SUBW, SLLW, SRLW, SRAW: r = {{32{w[31]}}, w};
        ANDL: r = a & b;
        ORL:  r = a | b;
        XORL: r = a ^ b;
        ANDN: r = a & ~b;
        ORN:  r = a | ~b;
        XNOR: r = a ^ ~b;
        SLL:  r = a << b[5:0];
        SRL:  r = a >> b[5:0];
        SRA:  r = $signed(a) >>> b[5:0];
        SLTS: r = xlen_t'($signed(a) < $signed(b));
        SLTU: r = xlen_t'(a < b);
        PL_R, PL_F, PL_G: begin
            for (int k = 0; k < 8; k++) begin
                r[8*k +: 8] = model_lane(op, $signed(a[8*k +: 8]), $signed(b[8*k +: 8]),
                                         imm_w[8*k +: 8], b[7:0] == 8'd1);
            end
        end
        PL_VADDREP, PL_SPCXOR: begin
            r = a;
            for (int k = 0; k < 8; k++) begin
                if (op == PL_VADDREP) begin
                    r = r + xlen_t'(b[8*k +: 8]);
                end else begin
                    r[7:0] = r[7:0] ^ b[8*k +: 8];
                end
            end
        end
        // Branches leave the result at zero
        default: r = '0;
    endcase
    return r;
endfunction

function automatic logic model_branch(alu_op_e op, xlen_t a, xlen_t b);
    case (op)
        EQ:      return a == b;
        NE:      return a != b;
        LTS:     return $signed(a) < $signed(b);
        LTU:     return a < b;
        GES:     return !($signed(a) < $signed(b));
        GEU:     return !(a < b);
        default: return 1'b1;
    endcase
endfunction

function automatic xlen_t rand_word();
    return {$urandom, $urandom};
endfunction

// Random imm with about half of the lanes zero
function automatic xlen_t rand_imm();
    xlen_t v;
    v = rand_word();
    for (int k = 0; k < 8; k++) begin
        if ($urandom_range(1) == 0) begin
            v[8*k +: 8] = 8'h00;
        end
    end
    return v;
endfunction

task automatic check_word(string name, xlen_t expected, xlen_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("MISMATCH %s result: expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic check_bit(string name, logic expected, logic actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("MISMATCH %s bit: expected %b, actual %b", name, expected, actual);
    end
endtask

// --------------------------------------------------
// Drive
// --------------------------------------------------
task automatic issue(string name, alu_op_e op_v, xlen_t a, xlen_t b, xlen_t imm_v);
    @(posedge clk);
    valid     <= 1'b1;
    op        <= op_v;
    operand_a <= a;
    operand_b <= b;
    imm       <= imm_v;
    exp_name_q.push_back($sformatf("%s %s", name, op_v.name()));
    exp_result_q.push_back(model_result(op_v, a, b, imm_v));
    exp_branch_q.push_back(model_branch(op_v, a, b));
    // Captured at the next edge, seen at the negedge after it
    exp_due_q.push_back(negedge_count + 2);
endtask

task automatic idle(int cycles);
    repeat (cycles) begin
        @(posedge clk);
        valid <= 1'b0;
    end
endtask

task automatic drain();
    idle(1);
    while (exp_due_q.size() > 0) begin
        idle(1);
    end
endtask

// --------------------------------------------------
// Directed tests
// --------------------------------------------------
task automatic test_reset();
    @(negedge clk);
    check_bit("reset valid_o", 1'b0, valid_out);
    check_word("reset result_o", '0, result);
    check_bit("reset branch_res_o", 1'b0, branch_res);
    idle(4);
endtask

task automatic test_arith_logic();
    alu_op_e ops[10]   = '{ADD, SUB, ADDW, SUBW, ANDL, ORL, XORL, ANDN, ORN, XNOR};
    xlen_t   corner[6] = '{64'h0, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
                           64'h7fff_ffff_ffff_ffff, 64'h0000_0000_8000_0000,
                           64'h0000_0000_7fff_ffff};
    foreach (ops[i]) begin
        foreach (corner[j]) begin
            foreach (corner[k]) begin
                issue("arith_logic", ops[i], corner[j], corner[k], '0);
            end
        end
        repeat (NUM_RANDOM) issue("arith_logic", ops[i], rand_word(), rand_word(), '0);
    end
    drain();
endtask

task automatic test_shifts();
    alu_op_e ops[6]     = '{SLL, SRL, SRA, SLLW, SRLW, SRAW};
    xlen_t   amounts[5] = '{64'd0, 64'd1, 64'd31, 64'd32, 64'd63};
    foreach (ops[i]) begin
        foreach (amounts[j]) begin
            // Upper bits of b carry junk that the shift must ignore
            issue("shifts", ops[i], 64'hc3a5_0f0f_8000_0001,
                  (rand_word() & ~64'h3f) | amounts[j], '0);
            issue("shifts", ops[i], rand_word(), amounts[j], '0);
        end
        repeat (NUM_RANDOM) issue("shifts", ops[i], rand_word(), rand_word(), '0);
    end
    drain();
endtask

task automatic test_compares();
    alu_op_e ops[8]    = '{SLTS, SLTU, EQ, NE, LTS, LTU, GES, GEU};
    xlen_t   pair_a[5] = '{64'h1234_5678_9abc_def0, 64'hffff_ffff_ffff_ffff, 64'h1,
                           64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff};
    xlen_t   pair_b[5] = '{64'h1234_5678_9abc_def0, 64'h1, 64'hffff_ffff_ffff_ffff,
                           64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000};
    foreach (ops[i]) begin
        foreach (pair_a[j]) begin
            issue("compares", ops[i], pair_a[j], pair_b[j], '0);
        end
        repeat (NUM_RANDOM) issue("compares", ops[i], rand_word(), rand_word(), '0);
    end
    drain();
endtask

task automatic test_polar();
    issue("polar", PL_R, 64'h807f_ff01_00c0_4081, 64'h5555_5555_5555_5501, '0);
    issue("polar", PL_R, 64'h807f_ff01_00c0_4081, 64'h5555_5555_5555_5502, '0);
    issue("polar", PL_R, 64'h807f_ff01_00c0_4081, 64'h0000_0000_0000_0181, '0);
    // Lane pairs with -128 and with equal magnitudes
    issue("polar", PL_F, 64'h8080_05fb_7f81_0010, 64'h8005_8005_817f_33f0, '0);
    issue("polar", PL_G, 64'h7f80_40c0_01ff_649c, 64'h7f80_40c0_0201_6464,
          64'h0000_0100_ff00_0080);
    issue("polar", PL_G, 64'h8181_7f7f_c0c0_4040, 64'h7f81_817f_c040_40c0,
          64'h0001_0001_0001_0001);
    repeat (NUM_RANDOM) begin
        issue("polar", PL_R, rand_word(), rand_word(), '0);
        issue("polar", PL_F, rand_word(), rand_word(), '0);
        issue("polar", PL_G, rand_word(), rand_word(), rand_imm());
    end
    drain();
endtask

task automatic test_streaming();
    alu_op_e ops[6] = '{PL_VADDREP, ADD, PL_SPCXOR, XORL, SRA, EQ};
    issue("streaming", PL_VADDREP, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, '0);
    repeat (2 * NUM_RANDOM) begin
        issue("streaming", ops[$urandom_range(5)], rand_word(), rand_word(), rand_word());
        if ($urandom_range(3) == 0) begin
            idle(1 + $urandom_range(1));
        end
    end
    drain();
endtask

// ==== dv/alu_tb.sv ====
// Testbench top of the polar ALU
//   Clock, reset and DUT
//   Result monitor against the reference queue
//   Watchdog and test sequence

`timescale 1ns/1ps

module alu_tb import alu_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int SEED         = 32'hc1bd51ba;
    localparam int NUM_RANDOM   = 20;
    // Issued operations of all tests together
    localparam int NUM_VECTORS  = 10 * (36 + NUM_RANDOM) + 6 * (10 + NUM_RANDOM) +
                                  8 * (5 + NUM_RANDOM) + 6 + 3 * NUM_RANDOM +
                                  1 + 2 * NUM_RANDOM;

    logic      clk;
    logic      reset;
    logic      valid;
    alu_op_e   op;
    xlen_t     operand_a;
    alu_word_u operand_b;
    alu_word_u imm;
    logic      valid_out;
    xlen_t     result;
    logic      branch_res;

    int error_count   = 0;
    int check_count   = 0;
    int negedge_count = 0;

    // Expected results in issue order
    string exp_name_q[$];
    xlen_t exp_result_q[$];
    logic  exp_branch_q[$];
    int    exp_due_q[$];

    // Last expected result, held by the DUT across idle cycles
    xlen_t held_result = '0;

    `include "alu_tb_tasks.svh"

    alu i_dut (
        .clk_i        (clk),
        .reset_i      (reset),
        .valid_i      (valid),
        .op_i         (op),
        .operand_a_i  (operand_a),
        .operand_b_i  (operand_b),
        .imm_i        (imm),
        .valid_o      (valid_out),
        .result_o     (result),
        .branch_res_o (branch_res)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // --------------------------------------------------
    // Monitor
    // --------------------------------------------------
    // Outputs are read mid-cycle, one negedge after the capturing edge
    always @(negedge clk) begin
        negedge_count++;
        if (!reset) begin
            if (exp_due_q.size() > 0 && exp_due_q[0] == negedge_count) begin
                if (!valid_out) begin
                    error_count++;
                    $display("ERROR %s: valid_o stayed low one cycle after issue",
                             exp_name_q[0]);
                end else begin
                    check_word(exp_name_q[0], exp_result_q[0], result);
                    check_bit(exp_name_q[0], exp_branch_q[0], branch_res);
                end
                held_result = exp_result_q[0];
                void'(exp_name_q.pop_front());
                void'(exp_result_q.pop_front());
                void'(exp_branch_q.pop_front());
                void'(exp_due_q.pop_front());
            end else if (valid_out) begin
                error_count++;
                $display("ERROR: valid_o high without an operation issued one cycle earlier");
            end else begin
                check_word("idle hold", held_result, result);
            end
        end
    end

    initial begin
        #(NUM_VECTORS * CLK_PERIOD * 4 + RESET_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired before the test sequence finished");
        $display("TESTS FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(SEED));
        reset     = 1'b1;
        // A live ADD during reset must not reach the outputs
        valid     = 1'b1;
        op        = ADD;
        operand_a = 64'h0123_4567_89ab_cdef;
        operand_b = '0;
        imm       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        valid <= 1'b0;

        test_reset();
        test_arith_logic();
        test_shifts();
        test_compares();
        test_polar();
        test_streaming();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== polar/polar_lane.sv ====
// One signed 8-bit lane of the polar decoder datapath
//   R kernel, hard decision from the LLR sign
//   F kernel, min-sum check-node update
//   G kernel, saturating add or subtract picked by the frozen flag

`timescale 1ns/1ps

module polar_lane import alu_pkg::*; (
    input  lane_t a_i,
    input  lane_t b_i,
    input  lane_t imm_i,
    input  logic  r_clear_i,
    output lane_t r_o,
    output lane_t f_o,
    output lane_t g_o
);

    logic                   sign_a;
    logic                   sign_b;
    logic [LANE_W-1:0]      mag_a;
    logic [LANE_W-1:0]      mag_b;
    logic [LANE_W-1:0]      mag_min;
    logic signed [LANE_W:0] g_sum;
    logic signed [LANE_W:0] g_diff;
    logic signed [LANE_W:0] g_raw;

    assign sign_a = a_i[LANE_W-1];
    assign sign_b = b_i[LANE_W-1];

    // R
    assign r_o = (!r_clear_i && sign_a) ? lane_t'(1) : '0;

    // --------------------------------------------------
    // F
    // --------------------------------------------------
    // -128 wraps back to 0x80, read as 128 unsigned
    assign mag_a   = sign_a ? -a_i : a_i;
    assign mag_b   = sign_b ? -b_i : b_i;
    // Tie keeps lane a
    assign mag_min = (mag_a > mag_b) ? mag_b : mag_a;
    assign f_o     = (sign_a ^ sign_b) ? -mag_min : mag_min;

    // --------------------------------------------------
    // G
    // --------------------------------------------------
    // Nine bits hold any sum or difference of two lanes
    assign g_sum  = {a_i[LANE_W-1], a_i} + {b_i[LANE_W-1], b_i};
    assign g_diff = {b_i[LANE_W-1], b_i} - {a_i[LANE_W-1], a_i};
    assign g_raw  = (imm_i == '0) ? g_sum : g_diff;

    // Symmetric clip, -128 is never produced
    always_comb begin
        if (g_raw > SAT_MAX) begin
            g_o = lane_t'(SAT_MAX);
        end else if (g_raw < -SAT_MAX) begin
            g_o = lane_t'(-SAT_MAX);
        end else begin
            g_o = g_raw[LANE_W-1:0];
        end
    end

    always_comb begin
        assert (g_o != {1'b1, {(LANE_W-1){1'b0}}})
            else $error("polar_lane: G result hit -128");
    end

endmodule

// ==== polar/polar_unit.sv ====
// Polar SIMD unit
//   Eight polar lanes over the packed operands
//   Byte-sum and byte-XOR reductions of operand b
//   Polar result select

`timescale 1ns/1ps

module polar_unit import alu_pkg::*; (
    input  alu_op_e   op_i,
    input  xlen_t     operand_a_i,
    input  alu_word_u operand_b_i,
    input  alu_word_u imm_i,
    output xlen_t     result_o
);

    logic                  r_clear;
    lane_t [NUM_LANES-1:0] r_lanes;
    lane_t [NUM_LANES-1:0] f_lanes;
    lane_t [NUM_LANES-1:0] g_lanes;
    xlen_t                 byte_sum;
    logic [LANE_W-1:0]     byte_xor;

    // R is cleared for every lane when b's low byte is exactly 1
    assign r_clear = (operand_b_i.lanes[0] == lane_t'(1));

    // --------------------------------------------------
    // Lanes
    // --------------------------------------------------
    for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
        polar_lane i_polar_lane (
            .a_i       (operand_a_i[g*LANE_W +: LANE_W]),
            .b_i       (operand_b_i.lanes[g]),
            .imm_i     (imm_i.lanes[g]),
            .r_clear_i (r_clear),
            .r_o       (r_lanes[g]),
            .f_o       (f_lanes[g]),
            .g_o       (g_lanes[g])
        );
    end

    // --------------------------------------------------
    // Reductions
    // --------------------------------------------------
    // Bytes of b taken as unsigned
    always_comb begin
        byte_sum = '0;
        byte_xor = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            byte_sum = byte_sum + {{(XLEN-LANE_W){1'b0}}, operand_b_i.lanes[k]};
            byte_xor = byte_xor ^ operand_b_i.lanes[k];
        end
    end

    always_comb begin
        case (op_i)
            PL_R:       result_o = r_lanes;
            PL_F:       result_o = f_lanes;
            PL_G:       result_o = g_lanes;
            PL_VADDREP: result_o = operand_a_i + byte_sum;
            // Upper bytes of a pass straight through
            PL_SPCXOR:  result_o = operand_a_i ^ {{(XLEN-LANE_W){1'b0}}, byte_xor};
            default:    result_o = '0;
        endcase
    end

endmodule

// ==== polar_alu.f ====
+incdir+dv
common/alu_pkg.sv
rtl/alu_arith.sv
rtl/alu_shifter.sv
polar/polar_lane.sv
polar/polar_unit.sv
rtl/alu.sv
dv/alu_tb.sv

// ==== rtl/alu.sv ====
// ALU top level
//   Arithmetic, shift and polar units in parallel
//   Logic operations, result select by operator class
//   One output register stage with valid

`timescale 1ns/1ps

module alu import alu_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      valid_i,
    input  alu_op_e   op_i,
    input  xlen_t     operand_a_i,
    input  alu_word_u operand_b_i,
    input  alu_word_u imm_i,
    output logic      valid_o,
    output xlen_t     result_o,
    output logic      branch_res_o
);

    xlen_t arith_result;
    xlen_t shift_result;
    xlen_t polar_result;
    xlen_t logic_result;
    xlen_t logic_b;
    xlen_t result_d;
    logic  branch_d;

    // --------------------------------------------------
    // Functional units
    // --------------------------------------------------
    alu_arith i_alu_arith (
        .op_i         (op_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i.word),
        .result_o     (arith_result),
        .branch_res_o (branch_d)
    );

    alu_shifter i_alu_shifter (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i.word),
        .result_o    (shift_result)
    );

    polar_unit i_polar_unit (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .imm_i       (imm_i),
        .result_o    (polar_result)
    );

    // --------------------------------------------------
    // Logic ops
    // --------------------------------------------------
    // Inverted forms use ~b
    assign logic_b = ((op_i == ANDN) || (op_i == ORN) || (op_i == XNOR)) ?
                     ~operand_b_i.word : operand_b_i.word;

    always_comb begin
        case (op_i)
            ANDL, ANDN: logic_result = operand_a_i & logic_b;
            ORL, ORN:   logic_result = operand_a_i | logic_b;
            XORL, XNOR: logic_result = operand_a_i ^ logic_b;
            default:    logic_result = '0;
        endcase
    end

    // Result select, branches write no register result
    always_comb begin
        case (op_class(op_i))
            CLS_ARITH: result_d = arith_result;
            CLS_LOGIC: result_d = logic_result;
            CLS_SHIFT: result_d = shift_result;
            CLS_POLAR: result_d = polar_result;
            default:   result_d = '0;
        endcase
    end

    // --------------------------------------------------
    // Output stage
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o      <= 1'b0;
            result_o     <= '0;
            branch_res_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            // Outputs hold across idle cycles
            if (valid_i) begin
                result_o     <= result_d;
                branch_res_o <= branch_d;
            end
        end
    end

    a_valid_op: assert property (
        @(posedge clk_i) disable iff (reset_i)
        valid_i |-> (!$isunknown(op_i) && (op_i <= PL_SPCXOR))
    ) else $error("alu: undefined operator issued");

endmodule

// ==== rtl/alu_arith.sv ====
// Arithmetic unit of the ALU
//   Shared adder for ADD/SUB and the word forms
//   Signed/unsigned less-than for SLT and branches
//   Branch resolution

`timescale 1ns/1ps

module alu_arith import alu_pkg::*; (
    input  alu_op_e op_i,
    input  xlen_t   operand_a_i,
    input  xlen_t   operand_b_i,
    output xlen_t   result_o,
    output logic    branch_res_o
);

    logic          negate_b;
    logic [XLEN:0] adder_in_a;
    logic [XLEN:0] adder_in_b;
    logic [XLEN:0] adder_sum;
    xlen_t         adder_result;
    logic          zero_flag;
    logic          is_signed;
    logic          less;

    // --------------------------------------------------
    // Adder
    // --------------------------------------------------
    assign negate_b = (op_i == SUB) || (op_i == SUBW) || (op_i == EQ) || (op_i == NE);

    // Extra LSB carries the +1 of the two's complement negation
    assign adder_in_a   = {operand_a_i, 1'b1};
    assign adder_in_b   = {operand_b_i, 1'b0} ^ {(XLEN+1){negate_b}};
    assign adder_sum    = adder_in_a + adder_in_b;
    assign adder_result = adder_sum[XLEN:1];
    assign zero_flag    = ~|adder_result;

    // --------------------------------------------------
    // Compare
    // --------------------------------------------------
    assign is_signed = (op_i == SLTS) || (op_i == LTS) || (op_i == GES);

    // Widen by one bit so a single signed compare serves both forms
    assign less = $signed({is_signed & operand_a_i[XLEN-1], operand_a_i}) <
                  $signed({is_signed & operand_b_i[XLEN-1], operand_b_i});

    always_comb begin
        case (op_i)
            EQ:       branch_res_o = zero_flag;
            NE:       branch_res_o = ~zero_flag;
            LTS, LTU: branch_res_o = less;
            GES, GEU: branch_res_o = ~less;
            default:  branch_res_o = 1'b1;
        endcase
    end

    always_comb begin
        case (op_i)
            ADD, SUB:   result_o = adder_result;
            // Word forms keep the low half, sign-extended
            ADDW, SUBW: result_o = {{(XLEN-WORD_W){adder_result[WORD_W-1]}},
                                   adder_result[WORD_W-1:0]};
            SLTS, SLTU: result_o = {{(XLEN-1){1'b0}}, less};
            default:    result_o = '0;
        endcase
    end

endmodule

// ==== rtl/alu_shifter.sv ====
// Shift unit of the ALU
//   64-bit and 32-bit right shifters, logical or arithmetic
//   Left shifts by reversing input and output bits

`timescale 1ns/1ps

module alu_shifter import alu_pkg::*; (
    input  alu_op_e op_i,
    input  xlen_t   operand_a_i,
    input  xlen_t   operand_b_i,
    output xlen_t   result_o
);

    logic                     shift_left;
    logic                     shift_arith;
    xlen_t                    shift_in64;
    logic signed [XLEN:0]     shift_ext64;
    logic signed [XLEN:0]     shift_out64;
    xlen_t                    result64;
    logic [WORD_W-1:0]        shift_in32;
    logic signed [WORD_W:0]   shift_ext32;
    logic signed [WORD_W:0]   shift_out32;
    logic [WORD_W-1:0]        result32;

    assign shift_left  = (op_i == SLL) || (op_i == SLLW);
    assign shift_arith = (op_i == SRA) || (op_i == SRAW);

    // --------------------------------------------------
    // 64-bit path
    // --------------------------------------------------
    assign shift_in64  = shift_left ? {<<{operand_a_i}} : operand_a_i;
    assign shift_ext64 = {shift_arith & shift_in64[XLEN-1], shift_in64};
    assign shift_out64 = shift_ext64 >>> operand_b_i[$clog2(XLEN)-1:0];
    assign result64    = shift_left ? {<<{shift_out64[XLEN-1:0]}} : shift_out64[XLEN-1:0];

    // --------------------------------------------------
    // 32-bit path
    // --------------------------------------------------
    assign shift_in32  = shift_left ? {<<{operand_a_i[WORD_W-1:0]}} : operand_a_i[WORD_W-1:0];
    assign shift_ext32 = {shift_arith & shift_in32[WORD_W-1], shift_in32};
    assign shift_out32 = shift_ext32 >>> operand_b_i[$clog2(WORD_W)-1:0];
    assign result32    = shift_left ? {<<{shift_out32[WORD_W-1:0]}} : shift_out32[WORD_W-1:0];

    always_comb begin
        case (op_i)
            SLL, SRL, SRA:    result_o = result64;
            // W results always sign-extend from bit 31
            SLLW, SRLW, SRAW: result_o = {{(XLEN-WORD_W){result32[WORD_W-1]}}, result32};
            default:          result_o = '0;
        endcase
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the polar ALU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module alu_tb \
    -f polar_alu.f -Mdir "$BUILD_DIR" -o alu_tb_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/alu_tb_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TESTS PASSED" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
